// ==== include/sort_config.svh ====
`ifndef SORT_CONFIG_SVH
`define SORT_CONFIG_SVH

`define KEY_WIDTH        16
`define VALUE_WIDTH      16

`define BANK_ADDR_WIDTH  7       // 128 rows, two tuples per row
`define BLOCK_SIZE       16
`define SORT_STAGES      10      // latency of the bitonic network

`define WB_ADDR_WIDTH    10
`define WB_DATA_WIDTH    32

// word addresses seen on the wishbone port
`define IN_BASE          10'h000
`define OUT_BASE         10'h100
`define CTRL_ADDR        10'h200
`define REGION_MASK      10'h300

`endif

// ==== src/tuple_pkg.sv ====
`default_nettype none

`include "sort_config.svh"

package tuple_pkg;

    typedef logic [`KEY_WIDTH-1:0]   key_t;
    typedef logic [`VALUE_WIDTH-1:0] value_t;

    // compared as one unsigned word, key above value
    typedef logic [$bits(key_t)+$bits(value_t)-1:0] tuple_t;

    typedef logic [`BANK_ADDR_WIDTH-1:0] bank_addr_t;
    typedef logic [`BANK_ADDR_WIDTH+1:0] tuple_idx_t;               // 0 to 256
    typedef logic [`BLOCK_SIZE*$bits(tuple_t)-1:0] block_flat_t;    // lane 0 in low bits

endpackage

`default_nettype wire

// ==== src/sort_ctrl_pkg.sv ====
`default_nettype none

`include "sort_config.svh"

package sort_ctrl_pkg;

    typedef enum logic [1:0] {LOAD_IDLE, LOAD_READ, LOAD_FIRE} load_state_t;
    typedef enum logic {WR_IDLE, WR_DRAIN} write_state_t;

    typedef logic [`WB_DATA_WIDTH-1:0] ctrl_word_t;
    localparam int CTRL_FLAG_BIT = 31;     // start on write, busy on read
    localparam int CTRL_LEN_MSB  = 8;      // length in bits 8..0

endpackage

`default_nettype wire

// ==== src/tuple_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module tuple_bank (
    input  wire logic                  clock,
    input  wire logic                  write_even_i,
    input  wire logic                  write_odd_i,
    input  wire tuple_pkg::bank_addr_t write_addr_i,
    input  wire tuple_pkg::tuple_t     write_data_i,       // even half
    input  wire tuple_pkg::tuple_t     write_data_odd_i,
    input  wire logic                  read_en_i,
    input  wire tuple_pkg::bank_addr_t read_addr_i,
    output tuple_pkg::tuple_t          read_even_o,
    output tuple_pkg::tuple_t          read_odd_o
);

    localparam int ROWS = 1 << $bits(tuple_pkg::bank_addr_t);

    tuple_pkg::tuple_t mem_even [ROWS];
    tuple_pkg::tuple_t mem_odd  [ROWS];

    always_ff @(posedge clock) begin
        if (write_even_i) begin
            mem_even[write_addr_i] <= write_data_i;
        end
        if (write_odd_i) begin
            mem_odd[write_addr_i] <= write_data_odd_i;
        end
    end

    // one cycle read, output holds while idle
    always_ff @(posedge clock) begin
        if (read_en_i) begin
            read_even_o <= mem_even[read_addr_i];
            read_odd_o  <= mem_odd[read_addr_i];
        end
    end

endmodule

`default_nettype wire

// ==== src/wb_tuple_port.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sort_config.svh"

module wb_tuple_port (
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire logic                     wb_cyc_i,
    input  wire logic                     wb_stb_i,
    input  wire logic                     wb_we_i,
    input  wire logic [`WB_ADDR_WIDTH-1:0] wb_adr_i,
    input  wire tuple_pkg::tuple_t        wb_dat_i,
    output logic [`WB_DATA_WIDTH-1:0]     wb_dat_o,
    output logic                          wb_ack_o,
    output logic                          in_wr_even_o,
    output logic                          in_wr_odd_o,
    output tuple_pkg::bank_addr_t         in_wr_addr_o,
    output tuple_pkg::tuple_t             in_wr_data_o,
    output logic                          out_rd_en_o,
    output tuple_pkg::bank_addr_t         out_rd_addr_o,
    input  wire tuple_pkg::tuple_t        out_rd_even_i,
    input  wire tuple_pkg::tuple_t        out_rd_odd_i,
    output tuple_pkg::tuple_idx_t         length_o,
    output logic                          start_o,
    input  wire logic                     busy_i
);

    localparam int ROW_MSB = $bits(tuple_pkg::bank_addr_t);

    logic req, in_hit, out_hit, ctrl_hit, ctrl_wr;
    logic rd_out_q, rd_ctrl_q, rd_odd_q;
    sort_ctrl_pkg::ctrl_word_t ctrl_rd;

    assign req      = wb_cyc_i && wb_stb_i && !wb_ack_o;    // gap cycle after every ack
    assign in_hit   = (wb_adr_i & `REGION_MASK) == `IN_BASE;
    assign out_hit  = (wb_adr_i & `REGION_MASK) == `OUT_BASE;
    assign ctrl_hit = wb_adr_i == `CTRL_ADDR;
    assign ctrl_wr  = req && wb_we_i && ctrl_hit;

    assign in_wr_addr_o  = wb_adr_i[ROW_MSB:1];              // bit 0 picks the half
    assign in_wr_data_o  = wb_dat_i;
    assign in_wr_even_o  = req && wb_we_i && in_hit && !wb_adr_i[0];
    assign in_wr_odd_o   = req && wb_we_i && in_hit && wb_adr_i[0];
    assign out_rd_en_o   = req && !wb_we_i && out_hit;
    assign out_rd_addr_o = wb_adr_i[ROW_MSB:1];

    always_ff @(posedge clock) begin
        if (reset) begin
            wb_ack_o  <= 1'b0;
            start_o   <= 1'b0;
            length_o  <= '0;
            rd_out_q  <= 1'b0;
            rd_ctrl_q <= 1'b0;
            rd_odd_q  <= 1'b0;
        end else begin
            wb_ack_o <= req;
            start_o  <= ctrl_wr && wb_dat_i[sort_ctrl_pkg::CTRL_FLAG_BIT];
            if (ctrl_wr) begin
                length_o <= wb_dat_i[sort_ctrl_pkg::CTRL_LEN_MSB:0];
            end
            if (req) begin
                rd_out_q  <= out_hit;
                rd_ctrl_q <= ctrl_hit;
                rd_odd_q  <= wb_adr_i[0];
            end
        end
    end

    always_comb begin
        ctrl_rd = '0;
        ctrl_rd[sort_ctrl_pkg::CTRL_FLAG_BIT] = busy_i;
        ctrl_rd[sort_ctrl_pkg::CTRL_LEN_MSB:0] = length_o;
    end

    // bank data is already registered, only the half is chosen here
    always_comb begin
        if (rd_ctrl_q) begin
            wb_dat_o = ctrl_rd;
        end else if (rd_out_q) begin
            wb_dat_o = rd_odd_q ? out_rd_odd_i : out_rd_even_i;
        end else begin
            wb_dat_o = '0;
        end
    end

endmodule

`default_nettype wire

// ==== src/bitonic_sort_16.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sort_config.svh"

module bitonic_sort_16 (
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire logic                   valid_i,
    input  wire tuple_pkg::block_flat_t block_i,
    output logic                        valid_o,
    output tuple_pkg::block_flat_t      block_o
);

    localparam int N     = `BLOCK_SIZE;
    localparam int LOG_N = $clog2(N);
    localparam int TW    = $bits(tuple_pkg::tuple_t);

    tuple_pkg::tuple_t lane_in [N];
    tuple_pkg::tuple_t stage_q [`SORT_STAGES][N];
    logic [`SORT_STAGES-1:0] valid_q;

    // smaller of the pair when take_min, larger otherwise
    function automatic tuple_pkg::tuple_t pick(
        input tuple_pkg::tuple_t a,
        input tuple_pkg::tuple_t b,
        input logic              take_min
    );
        return ((a < b) == take_min) ? a : b;
    endfunction

    always_comb begin
        for (int i = 0; i < N; i++) begin
            lane_in[i] = block_i[i*TW +: TW];
        end
    end

    // merge size 2^kk, then steps with partner distance halving
    for (genvar kk = 1; kk <= LOG_N; kk++) begin : g_merge
        for (genvar t = 0; t < kk; t++) begin : g_step
            localparam int S    = kk * (kk - 1) / 2 + t;
            localparam int DIST = 1 << (kk - 1 - t);

            tuple_pkg::tuple_t src [N];

            if (S == 0) begin : g_first
                assign src = lane_in;
            end else begin : g_next
                assign src = stage_q[S-1];
            end

            always_ff @(posedge clock) begin
                for (int i = 0; i < N; i++) begin
                    // lower lane of an ascending pair keeps the minimum
                    stage_q[S][i] <= pick(src[i], src[i ^ DIST],
                                          (i < (i ^ DIST)) == (((i >> kk) & 1) == 0));
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[`SORT_STAGES-2:0], valid_i};
        end
    end

    assign valid_o = valid_q[`SORT_STAGES-1];

    always_comb begin
        for (int i = 0; i < N; i++) begin
            block_o[i*TW +: TW] = stage_q[`SORT_STAGES-1][i];
        end
    end

endmodule

`default_nettype wire

// ==== src/block_sorter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sort_config.svh"

module block_sorter (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire logic                  start_i,
    input  wire tuple_pkg::tuple_idx_t length_i,
    output logic                       busy_o,
    output logic                       done_o,
    output logic                       in_rd_en_o,
    output tuple_pkg::bank_addr_t      in_rd_addr_o,
    input  wire tuple_pkg::tuple_t     in_rd_even_i,
    input  wire tuple_pkg::tuple_t     in_rd_odd_i,
    output logic                       out_wr_even_o,
    output logic                       out_wr_odd_o,
    output tuple_pkg::bank_addr_t      out_wr_addr_o,
    output tuple_pkg::tuple_t          out_wr_data_even_o,
    output tuple_pkg::tuple_t          out_wr_data_odd_o
);

    localparam int TW       = $bits(tuple_pkg::tuple_t);
    localparam int ROW_BITS = $clog2(`BLOCK_SIZE / 2);
    localparam int BLK_BITS = `BANK_ADDR_WIDTH - ROW_BITS;

    sort_ctrl_pkg::load_state_t  load_q;
    sort_ctrl_pkg::write_state_t wr_q;

    tuple_pkg::tuple_idx_t  length_q, cap_idx, wr_idx;
    tuple_pkg::block_flat_t block_q, net_block_out, sorted_q;
    logic [BLK_BITS:0]      nblk_q, issued_q, written_q, start_blocks;
    logic [ROW_BITS-1:0]    row_q, cap_row_q, wr_row_q;
    logic cap_q, net_valid_q, net_valid_out, start_go, drain_last, last_block;

    assign start_go     = start_i && !busy_o;
    assign start_blocks = (BLK_BITS+1)'((length_i + (`BLOCK_SIZE - 1)) >> $clog2(`BLOCK_SIZE));
    assign cap_idx      = tuple_pkg::tuple_idx_t'({issued_q[BLK_BITS-1:0], cap_row_q, 1'b0});
    assign wr_idx       = tuple_pkg::tuple_idx_t'({written_q[BLK_BITS-1:0], wr_row_q, 1'b0});
    assign drain_last   = (wr_row_q == '1) || (wr_idx + 2'd2 >= length_q);   // next row empty
    assign last_block   = (load_q == sort_ctrl_pkg::LOAD_IDLE) && (written_q + 1'b1 == issued_q);

    assign in_rd_en_o         = (load_q == sort_ctrl_pkg::LOAD_READ);
    assign in_rd_addr_o       = {issued_q[BLK_BITS-1:0], row_q};
    assign out_wr_addr_o      = {written_q[BLK_BITS-1:0], wr_row_q};
    assign out_wr_even_o      = (wr_q == sort_ctrl_pkg::WR_DRAIN) && (wr_idx < length_q);
    assign out_wr_odd_o       = (wr_q == sort_ctrl_pkg::WR_DRAIN) && (wr_idx + 1'b1 < length_q);
    assign out_wr_data_even_o = sorted_q[TW-1:0];
    assign out_wr_data_odd_o  = sorted_q[2*TW-1:TW];

    always_ff @(posedge clock) begin
        if (reset) begin
            load_q      <= sort_ctrl_pkg::LOAD_IDLE;
            row_q       <= '0;
            issued_q    <= '0;
            cap_q       <= 1'b0;
            net_valid_q <= 1'b0;
        end else begin
            cap_q       <= (load_q == sort_ctrl_pkg::LOAD_READ);
            net_valid_q <= (load_q == sort_ctrl_pkg::LOAD_FIRE);   // block_q complete now
            case (load_q)
                sort_ctrl_pkg::LOAD_IDLE: begin
                    if (start_go && start_blocks != '0) begin
                        load_q   <= sort_ctrl_pkg::LOAD_READ;
                        row_q    <= '0;
                        issued_q <= '0;
                    end
                end
                sort_ctrl_pkg::LOAD_READ: begin
                    row_q <= row_q + 1'b1;
                    if (row_q == '1) begin
                        load_q <= sort_ctrl_pkg::LOAD_FIRE;
                    end
                end
                default: begin
                    issued_q <= issued_q + 1'b1;
                    load_q   <= (issued_q + 1'b1 < nblk_q) ? sort_ctrl_pkg::LOAD_READ
                                                            : sort_ctrl_pkg::LOAD_IDLE;
                end
            endcase
        end
    end

    // row data lands one cycle after the read, tail lanes get all-ones
    always_ff @(posedge clock) begin
        cap_row_q <= row_q;
        if (cap_q) begin
            block_q[int'(cap_row_q)*2*TW +: TW]     <= (cap_idx >= length_q) ? '1 : in_rd_even_i;
            block_q[(int'(cap_row_q)*2+1)*TW +: TW] <= (cap_idx + 1'b1 >= length_q) ? '1
                                                                                  : in_rd_odd_i;
        end
        if (net_valid_out) begin
            sorted_q <= net_block_out;
        end else if (wr_q == sort_ctrl_pkg::WR_DRAIN) begin
            sorted_q <= sorted_q >> (2 * TW);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_q      <= sort_ctrl_pkg::WR_IDLE;
            wr_row_q  <= '0;
            written_q <= '0;
            length_q  <= '0;
            nblk_q    <= '0;
            busy_o    <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_go) begin
                length_q  <= length_i;
                nblk_q    <= start_blocks;
                written_q <= '0;
                busy_o    <= (start_blocks != '0);
                done_o    <= (start_blocks == '0);     // empty sort
            end
            if (wr_q == sort_ctrl_pkg::WR_IDLE) begin
                if (net_valid_out) begin
                    wr_q     <= sort_ctrl_pkg::WR_DRAIN;
                    wr_row_q <= '0;
                end
            end else begin
                wr_row_q <= wr_row_q + 1'b1;
                if (drain_last) begin
                    wr_q      <= sort_ctrl_pkg::WR_IDLE;
                    written_q <= written_q + 1'b1;
                    if (last_block) begin
                        busy_o <= 1'b0;
                        done_o <= 1'b1;
                    end
                end
            end
        end
    end

    bitonic_sort_16 u_network (
        .clock   (clock),
        .reset   (reset),
        .valid_i (net_valid_q),
        .block_i (block_q),
        .valid_o (net_valid_out),
        .block_o (net_block_out)
    );

endmodule

`default_nettype wire

// ==== src/tuple_sort_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sort_config.svh"

module tuple_sort_top (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire logic                      wb_cyc_i,
    input  wire logic                      wb_stb_i,
    input  wire logic                      wb_we_i,
    input  wire logic [`WB_ADDR_WIDTH-1:0] wb_adr_i,
    input  wire tuple_pkg::tuple_t         wb_dat_i,
    output logic [`WB_DATA_WIDTH-1:0]      wb_dat_o,
    output logic                           wb_ack_o,
    output logic                           done_o
);

    tuple_pkg::bank_addr_t in_wr_addr, in_rd_addr, out_wr_addr, out_rd_addr;
    tuple_pkg::tuple_t     in_wr_data, in_rd_even, in_rd_odd;
    tuple_pkg::tuple_t     out_wr_data_even, out_wr_data_odd, out_rd_even, out_rd_odd;
    tuple_pkg::tuple_idx_t length;
    logic in_wr_even, in_wr_odd, in_rd_en, out_wr_even, out_wr_odd, out_rd_en;
    logic start, busy;

    wb_tuple_port u_port (
        .clock         (clock),
        .reset         (reset),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .in_wr_even_o  (in_wr_even),
        .in_wr_odd_o   (in_wr_odd),
        .in_wr_addr_o  (in_wr_addr),
        .in_wr_data_o  (in_wr_data),
        .out_rd_en_o   (out_rd_en),
        .out_rd_addr_o (out_rd_addr),
        .out_rd_even_i (out_rd_even),
        .out_rd_odd_i  (out_rd_odd),
        .length_o      (length),
        .start_o       (start),
        .busy_i        (busy)
    );

    // host writes one tuple at a time, either half takes the same data
    tuple_bank in_bank (
        .clock            (clock),
        .write_even_i     (in_wr_even),
        .write_odd_i      (in_wr_odd),
        .write_addr_i     (in_wr_addr),
        .write_data_i     (in_wr_data),
        .write_data_odd_i (in_wr_data),
        .read_en_i        (in_rd_en),
        .read_addr_i      (in_rd_addr),
        .read_even_o      (in_rd_even),
        .read_odd_o       (in_rd_odd)
    );

    tuple_bank out_bank (
        .clock            (clock),
        .write_even_i     (out_wr_even),
        .write_odd_i      (out_wr_odd),
        .write_addr_i     (out_wr_addr),
        .write_data_i     (out_wr_data_even),
        .write_data_odd_i (out_wr_data_odd),
        .read_en_i        (out_rd_en),
        .read_addr_i      (out_rd_addr),
        .read_even_o      (out_rd_even),
        .read_odd_o       (out_rd_odd)
    );

    block_sorter u_sorter (
        .clock              (clock),
        .reset              (reset),
        .start_i            (start),
        .length_i           (length),
        .busy_o             (busy),
        .done_o             (done_o),
        .in_rd_en_o         (in_rd_en),
        .in_rd_addr_o       (in_rd_addr),
        .in_rd_even_i       (in_rd_even),
        .in_rd_odd_i        (in_rd_odd),
        .out_wr_even_o      (out_wr_even),
        .out_wr_odd_o       (out_wr_odd),
        .out_wr_addr_o      (out_wr_addr),
        .out_wr_data_even_o (out_wr_data_even),
        .out_wr_data_odd_o  (out_wr_data_odd)
    );

endmodule

`default_nettype wire

// ==== sim/tuple_sort_props.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sort_config.svh"

module tuple_sort_props #(
    parameter bit CHECK_BUS = 1'b0
) (
    input wire logic clock,
    input wire logic reset,
    input wire logic bus_req_i,
    input wire logic ack_i,
    input wire logic net_valid_in_i,
    input wire logic net_valid_out_i,
    input wire logic done_i,
    input wire logic busy_i
);

    if (CHECK_BUS) begin : g_bus
        ack_one_cycle: assert property (@(posedge clock) disable iff (reset)
            ack_i |=> !ack_i)
            else $error("wishbone ack held for more than one cycle");

        ack_after_strobe: assert property (@(posedge clock) disable iff (reset)
            ack_i |-> $past(bus_req_i))
            else $error("wishbone ack without cyc and stb on the cycle before");
    end else begin : g_sorter
        // network latency is fixed, no back-pressure
        net_latency: assert property (@(posedge clock) disable iff (reset)
            net_valid_out_i == $past(net_valid_in_i, `SORT_STAGES))
            else $error("network valid_o does not follow valid_i by the pipeline depth");

        done_one_cycle: assert property (@(posedge clock) disable iff (reset)
            done_i |=> !done_i)
            else $error("done held for more than one cycle");

        busy_falls_with_done: assert property (@(posedge clock) disable iff (reset)
            (!busy_i && $past(busy_i)) |-> done_i)
            else $error("busy fell without done");
    end

endmodule

// each instance builds only the checks whose signals live in the bound module
bind wb_tuple_port tuple_sort_props #(.CHECK_BUS(1'b1)) bus_props (
    .clock           (clock),
    .reset           (reset),
    .bus_req_i       (wb_cyc_i && wb_stb_i),
    .ack_i           (wb_ack_o),
    .net_valid_in_i  (1'b0),
    .net_valid_out_i (1'b0),
    .done_i          (1'b0),
    .busy_i          (1'b0)
);

bind block_sorter tuple_sort_props #(.CHECK_BUS(1'b0)) sorter_props (
    .clock           (clock),
    .reset           (reset),
    .bus_req_i       (1'b0),
    .ack_i           (1'b0),
    .net_valid_in_i  (net_valid_q),
    .net_valid_out_i (net_valid_out),
    .done_i          (done_o),
    .busy_i          (busy_o)
);

`default_nettype wire

// ==== sim/tuple_sort_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sort_config.svh"

module tuple_sort_tb;

    localparam int RESET_CYCLES    = 16;
    localparam int TUPLES_TESTED   = 365;    // 64 + 37 + 48 + 16 + 200
    localparam int WATCHDOG_CYCLES = 40 * TUPLES_TESTED + RESET_CYCLES;
    localparam int MAX_TUPLES      = 2 * (1 << `BANK_ADDR_WIDTH);

    logic clock;
    logic reset;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic wb_ack;
    logic done;
    logic [`WB_ADDR_WIDTH-1:0] wb_adr;
    logic [`WB_DATA_WIDTH-1:0] wb_dat_r;
    tuple_pkg::tuple_t         wb_dat_w;

    tuple_pkg::tuple_t model_in  [MAX_TUPLES];
    tuple_pkg::tuple_t model_out [MAX_TUPLES];
    logic [31:0] rng_state;
    string       waiting_for;

    tuple_sort_top UUT (
        .clock    (clock),
        .reset    (reset),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack),
        .done_o   (done)
    );

    always #10 clock = ~clock;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic fail_and_stop;
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_tuple(input string name, input tuple_pkg::tuple_t expected,
                               input tuple_pkg::tuple_t actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            fail_and_stop();
        end
    endtask

    task automatic check_ctrl(input string name, input sort_ctrl_pkg::ctrl_word_t expected,
                              input sort_ctrl_pkg::ctrl_word_t actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            fail_and_stop();
        end
    endtask

    // entered and left on a falling edge; ack is seen on the next one
    task automatic bus_access(input logic we, input logic [`WB_ADDR_WIDTH-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        waiting_for = "wishbone ack";
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = addr;
        wb_dat_w = wdata;
        do begin
            @(negedge clock);
        end while (wb_ack !== 1'b1);
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_write(input logic [`WB_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(1'b1, addr, data, unused);
    endtask

    task automatic bus_read(input logic [`WB_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
        bus_access(1'b0, addr, 32'h0, data);
    endtask

    task automatic load_random(input int len, input logic tied_keys);
        tuple_pkg::tuple_t t;
        for (int i = 0; i < len; i++) begin
            rng_state = xorshift32(rng_state);
            t = rng_state;
            if (tied_keys) begin
                t[31:16] = tuple_pkg::key_t'(rng_state[31:30]) * 16'h3c01;  // four keys
            end
            model_in[i] = t;
            bus_write(`WB_ADDR_WIDTH'(`IN_BASE + i), t);
        end
    endtask

    task automatic run_sort(input int len);
        bus_write(`CTRL_ADDR, 32'h8000_0000 | 32'(len));
        waiting_for = "done pulse";
        do begin
            @(negedge clock);
        end while (done !== 1'b1);
    endtask

    // each group of sixteen padded with all-ones, sorted ascending as 32-bit words
    task automatic build_expected(input int len);
        tuple_pkg::tuple_t blk [`BLOCK_SIZE];
        tuple_pkg::tuple_t t;
        int j;
        for (int b = 0; b < len; b += `BLOCK_SIZE) begin
            for (int i = 0; i < `BLOCK_SIZE; i++) begin
                blk[i] = (b + i < len) ? model_in[b + i] : 32'hffff_ffff;
            end
            for (int i = 1; i < `BLOCK_SIZE; i++) begin
                t = blk[i];
                j = i - 1;
                while (j >= 0 && blk[j] > t) begin
                    blk[j + 1] = blk[j];
                    j--;
                end
                blk[j + 1] = t;
            end
            for (int i = 0; i < `BLOCK_SIZE && b + i < len; i++) begin
                model_out[b + i] = blk[i];
            end
        end
    endtask

    task automatic check_outputs(input string name, input int len);
        logic [31:0] d;
        for (int i = 0; i < len; i++) begin
            bus_read(`WB_ADDR_WIDTH'(`OUT_BASE + i), d);
            check_tuple($sformatf("%s[%0d]", name, i), model_out[i], d);
        end
    endtask

    task automatic read_ctrl(input string name, input sort_ctrl_pkg::ctrl_word_t expected);
        logic [31:0] d;
        bus_read(`CTRL_ADDR, d);
        check_ctrl(name, expected, d);
    endtask

    task automatic sort_and_check(input string name, input int len, input logic tied_keys);
        load_random(len, tied_keys);
        run_sort(len);
        build_expected(len);
        check_outputs(name, len);
    endtask

    initial begin
        clock       = 1'b0;
        reset       = 1'b1;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        rng_state   = 32'h715dcbb8;
        waiting_for = "end of reset";
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        read_ctrl("ctrl_after_reset", 32'h0);
        sort_and_check("random_64", 64, 1'b0);
        sort_and_check("tail_pad_37", 37, 1'b0);
        read_ctrl("ctrl_after_37", 32'd37);                 // busy clear, length kept
        sort_and_check("tied_keys_48", 48, 1'b1);
        sort_and_check("back_to_back_16", 16, 1'b0);
        sort_and_check("back_to_back_200", 200, 1'b0);

        // empty sort must leave the last results untouched
        run_sort(0);
        check_outputs("empty_sort_keeps_200", 200);
        read_ctrl("ctrl_after_empty", 32'h0);

        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("timeout while waiting for %s", waiting_for);
        fail_and_stop();
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
src/tuple_pkg.sv
src/sort_ctrl_pkg.sv
src/tuple_bank.sv
src/wb_tuple_port.sv
src/bitonic_sort_16.sv
src/block_sorter.sv
src/tuple_sort_top.sv
sim/tuple_sort_props.sv
sim/tuple_sort_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --timing --assert -Wno-fatal
TOP      = tuple_sort_tb
FILELIST = sources.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
